/* hdl/mmc5_pkg.sv */
package mmc5_pkg;

	//**********************************************************************
	// address layout

	localparam int XRAM_AW = 10;                         // 1 KB expansion RAM
	localparam int PPU_AW = 14;                          // PPU bus, bit 13 = nametable space
	localparam logic [7:0] SPR_FETCH_FIRST = 8'd128;     // sprite pattern window start
	localparam logic [7:0] SPR_FETCH_LAST = 8'd158;      // sprite pattern window end
	localparam int FETCH_PER_TILE_LOG = 2;               // NT, AT, pat lo, pat hi

	//**********************************************************************
	// register select for the CPU-side write port

	typedef enum logic [2:0]
	{
		SEL_IRQ_VAL    = 3'd0,   // target scanline
		SEL_IRQ_CTRL   = 3'd1,   // bit 7 enables the interrupt
		SEL_SPLIT_MODE = 3'd2,   // on, side, tile position
		SEL_SPLIT_SCRL = 3'd3,   // vertical scroll of the split
		SEL_SPLIT_BANK = 3'd4,   // 4 KB CHR bank used inside the split
		SEL_XRAM       = 3'd5    // byte write into expansion RAM
	} reg_sel_t;

	// what a PPU read is fetching
	typedef enum logic [1:0]
	{
		FETCH_PAT = 2'd0,        // pattern table, bit 13 clear
		FETCH_NT  = 2'd1,        // nametable byte
		FETCH_AT  = 2'd2         // attribute byte, bits 9..6 all ones
	} fetch_kind_t;

endpackage

/* hdl/mapper_regs.sv */
`timescale 1ns/1ps

module mapper_regs
(
	input  logic                         ppu_oe,
	input  logic                         cfg_we,
	input  mmc5_pkg::reg_sel_t           cfg_sel,
	input  logic [mmc5_pkg::XRAM_AW-1:0] cfg_addr,
	input  logic [7:0]                   cfg_data,
	output logic [7:0]                   irq_val,
	output logic                         irq_on,
	output logic                         split_on,
	output logic                         split_side,
	output logic [5:0]                   split_pos,
	output logic [7:0]                   split_scrl,
	output logic [7:0]                   split_bank,
	output logic                         xram_we,
	output logic [mmc5_pkg::XRAM_AW-1:0] xram_wr_addr,
	output logic [7:0]                   xram_wr_data
);
	import mmc5_pkg::*;

	// CPU owns these across frames, in_frame leaves them alone
	always_ff @(posedge ppu_oe)
	begin
		if (cfg_we)
		begin
			case (cfg_sel)
				SEL_IRQ_VAL:    irq_val <= cfg_data;
				SEL_IRQ_CTRL:   irq_on <= cfg_data[7];
				SEL_SPLIT_MODE:
				begin
					split_on   <= cfg_data[7];
					split_side <= cfg_data[6];     // 1 = split on the right
					split_pos  <= cfg_data[5:0];   // boundary in tiles
				end
				SEL_SPLIT_SCRL: split_scrl <= cfg_data;
				SEL_SPLIT_BANK: split_bank <= cfg_data;
				default: ;                         // SEL_XRAM goes to the RAM port
			endcase
		end
	end

	// expansion RAM byte lands at the same edge as the strobe
	assign xram_we      = cfg_we && (cfg_sel == SEL_XRAM);
	assign xram_wr_addr = cfg_addr;
	assign xram_wr_data = cfg_data;

endmodule

/* hdl/ppu_fetch_tracker.sv */
`timescale 1ns/1ps

module ppu_fetch_tracker
(
	input  logic                        ppu_oe,
	input  logic                        in_frame,
	input  logic [mmc5_pkg::PPU_AW-1:0] ppu_addr,
	output logic [mmc5_pkg::PPU_AW-1:0] addr_q,
	output mmc5_pkg::fetch_kind_t       fetch_kind,
	output logic                        line_start,
	output logic [7:0]                  fetch_idx,
	output logic                        spr_fetch
);
	import mmc5_pkg::*;

	logic [PPU_AW-1:0] addr_prev;     // read before addr_q
	logic              marker;
	fetch_kind_t       kind_in;

	// three identical nametable reads in a row, a fourth repeat does not restart the line
	assign marker = ppu_addr[PPU_AW-1] && (ppu_addr == addr_q) && (addr_q == addr_prev) &&
		!line_start;

	always_comb
	begin
		if (!ppu_addr[PPU_AW-1])
			kind_in = FETCH_PAT;
		else if (ppu_addr[9:6] == 4'b1111)
			kind_in = FETCH_AT;
		else
			kind_in = FETCH_NT;
	end

	always_ff @(posedge ppu_oe or negedge in_frame)
	begin
		if (!in_frame)
		begin
			addr_prev  <= '0;                  // bit 13 clear, no false marker
			addr_q     <= '0;
			fetch_kind <= FETCH_PAT;
			line_start <= 1'b0;
			fetch_idx  <= 8'd0;
		end
		else
		begin
			addr_prev  <= addr_q;
			addr_q     <= ppu_addr;
			fetch_kind <= kind_in;
			line_start <= marker;
			fetch_idx  <= marker ? 8'd0 : fetch_idx + 8'd1;   // 0 alongside line_start
		end
	end

	assign spr_fetch = (fetch_idx >= SPR_FETCH_FIRST) && (fetch_idx <= SPR_FETCH_LAST);

endmodule

/* hdl/scanline_irq.sv */
`timescale 1ns/1ps

module scanline_irq
(
	input  logic       ppu_oe,
	input  logic       in_frame,
	input  logic       line_start,
	input  logic [7:0] irq_val,
	input  logic       irq_on,
	input  logic       irq_ack,
	output logic       irq
);

	logic [7:0] line_cnt;      // markers seen this frame
	logic       irq_pend;

	always_ff @(posedge ppu_oe or negedge in_frame)
	begin
		if (!in_frame)
		begin
			line_cnt <= 8'd0;
			irq_pend <= 1'b0;
		end
		else
		begin
			if (line_start)
				line_cnt <= line_cnt + 8'd1;
			// compare uses the count before this marker's increment
			if (irq_ack)
				irq_pend <= 1'b0;              // ack wins over a new hit
			else if (line_start && (line_cnt == irq_val))
				irq_pend <= 1'b1;
		end
	end

	assign irq = irq_pend & irq_on;

endmodule

/* hdl/split_screen.sv */
`timescale 1ns/1ps

module split_screen
(
	input  logic                         ppu_oe,
	input  logic                         in_frame,
	input  logic [mmc5_pkg::PPU_AW-1:0]  addr_q,
	input  mmc5_pkg::fetch_kind_t        fetch_kind,
	input  logic                         line_start,
	input  logic [7:0]                   fetch_idx,
	input  logic                         spr_fetch,
	input  logic                         split_on,
	input  logic                         split_side,
	input  logic [5:0]                   split_pos,
	input  logic [7:0]                   split_scrl,
	input  logic [7:0]                   split_bank,
	output logic [mmc5_pkg::XRAM_AW-1:0] xram_rd_addr,
	output logic                         split_act,
	output logic [9:0]                   split_chr_bank
);
	import mmc5_pkg::*;

	logic [1:0]         vld;           // [0] addr_q is real, [1] stage 1 is real
	logic [7:0]         row;
	logic [7:0]         row_cur;
	logic [7:0]         row_next;
	logic [7:0]         idx_tile;
	logic [5:0]         col;
	logic [5:0]         col_s1;
	logic [4:0]         tile_row_s1;
	fetch_kind_t        kind_s1;
	logic [1:0]         bank_lo_s1;
	logic               in_split;
	logic               act_s2;
	logic [XRAM_AW-1:0] nt_addr;
	logic [XRAM_AW-1:0] at_addr;

	//**********************************************************************
	// tile position

	assign idx_tile = fetch_idx >> FETCH_PER_TILE_LOG;
	assign col      = spr_fetch ? 6'd0 : idx_tile[5:0];    // sprite fetches park at column 0

	// first cycle of the frame starts from the programmed scroll
	assign row_cur  = vld[0] ? row : {split_scrl[7:3], 3'b000};
	assign row_next = row_cur + {7'd0, line_start};

	//**********************************************************************
	// split decision and RAM address

	assign in_split = split_on && ((col_s1 < split_pos) != split_side);
	assign nt_addr  = {tile_row_s1, col_s1[4:0]};
	assign at_addr  = {4'b1111, tile_row_s1[4:2], col_s1[4:2]};   // 8x8 attribute grid

	always_ff @(posedge ppu_oe or negedge in_frame)
	begin
		if (!in_frame)
		begin
			vld       <= 2'b00;
			row       <= 8'd0;
			act_s2    <= 1'b0;
			split_act <= 1'b0;
		end
		else
		begin
			vld       <= {vld[0], 1'b1};
			row       <= row_next;
			act_s2    <= in_split && vld[1];
			split_act <= act_s2;               // lines up with rd_data from exram
		end
	end

	always_ff @(posedge ppu_oe)
	begin
		col_s1         <= col;
		tile_row_s1    <= row_next[7:3];
		kind_s1        <= fetch_kind;
		bank_lo_s1     <= addr_q[11:10];
		xram_rd_addr   <= (kind_s1 == FETCH_AT) ? at_addr : nt_addr;
		split_chr_bank <= {split_bank, bank_lo_s1};
	end

endmodule

/* hdl/exram.sv */
`timescale 1ns/1ps

module exram
(
	input  logic                         ppu_oe,
	input  logic                         we,
	input  logic [mmc5_pkg::XRAM_AW-1:0] wr_addr,
	input  logic [7:0]                   wr_data,
	input  logic [mmc5_pkg::XRAM_AW-1:0] rd_addr,
	output logic [7:0]                   rd_data
);
	import mmc5_pkg::*;

	logic [7:0] mem [0:(1 << XRAM_AW)-1];

	// same-address collision returns the byte before the write
	always_ff @(posedge ppu_oe)
	begin
		if (we)
			mem[wr_addr] <= wr_data;
		rd_data <= mem[rd_addr];
	end

endmodule

/* hdl/mmc5_scanline_unit.sv */
`timescale 1ns/1ps

module mmc5_scanline_unit
(
	input  logic                         ppu_oe,
	input  logic                         in_frame,
	input  logic [mmc5_pkg::PPU_AW-1:0]  ppu_addr,
	input  logic                         cfg_we,
	input  mmc5_pkg::reg_sel_t           cfg_sel,
	input  logic [mmc5_pkg::XRAM_AW-1:0] cfg_addr,
	input  logic [7:0]                   cfg_data,
	input  logic                         irq_ack,
	output logic                         irq,
	output logic                         split_act,
	output logic [9:0]                   split_chr_bank,
	output logic [7:0]                   split_data
);
	import mmc5_pkg::*;

	logic [7:0]         irq_val;
	logic               irq_on;
	logic               split_on;
	logic               split_side;
	logic [5:0]         split_pos;
	logic [7:0]         split_scrl;
	logic [7:0]         split_bank;
	logic               xram_we;
	logic [XRAM_AW-1:0] xram_wr_addr;
	logic [7:0]         xram_wr_data;
	logic [PPU_AW-1:0]  addr_q;
	fetch_kind_t        fetch_kind;
	logic               line_start;
	logic [7:0]         fetch_idx;
	logic               spr_fetch;
	logic [XRAM_AW-1:0] xram_rd_addr;

	//**********************************************************************
	// side blocks

	mapper_regs u_regs
	(
		.ppu_oe(ppu_oe), .cfg_we(cfg_we), .cfg_sel(cfg_sel), .cfg_addr(cfg_addr),
		.cfg_data(cfg_data), .irq_val(irq_val), .irq_on(irq_on), .split_on(split_on),
		.split_side(split_side), .split_pos(split_pos), .split_scrl(split_scrl),
		.split_bank(split_bank), .xram_we(xram_we), .xram_wr_addr(xram_wr_addr),
		.xram_wr_data(xram_wr_data)
	);

	scanline_irq u_irq
	(
		.ppu_oe(ppu_oe), .in_frame(in_frame), .line_start(line_start), .irq_val(irq_val),
		.irq_on(irq_on), .irq_ack(irq_ack), .irq(irq)
	);

	//**********************************************************************
	// fetch tracking -> split position -> expansion RAM read

	ppu_fetch_tracker u_track
	(
		.ppu_oe(ppu_oe), .in_frame(in_frame), .ppu_addr(ppu_addr), .addr_q(addr_q),
		.fetch_kind(fetch_kind), .line_start(line_start), .fetch_idx(fetch_idx),
		.spr_fetch(spr_fetch)
	);

	split_screen u_split
	(
		.ppu_oe(ppu_oe), .in_frame(in_frame), .addr_q(addr_q), .fetch_kind(fetch_kind),
		.line_start(line_start), .fetch_idx(fetch_idx), .spr_fetch(spr_fetch),
		.split_on(split_on), .split_side(split_side), .split_pos(split_pos),
		.split_scrl(split_scrl), .split_bank(split_bank), .xram_rd_addr(xram_rd_addr),
		.split_act(split_act), .split_chr_bank(split_chr_bank)
	);

	exram u_xram
	(
		.ppu_oe(ppu_oe), .we(xram_we), .wr_addr(xram_wr_addr), .wr_data(xram_wr_data),
		.rd_addr(xram_rd_addr), .rd_data(split_data)
	);

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock
(
	output logic ppu_oe,
	output logic init_n
);

	initial
	begin
		ppu_oe = 1'b0;
		forever #20 ppu_oe = ~ppu_oe;      // 40 ns period
	end

	// no frame during the first 4 cycles
	initial
	begin
		init_n = 1'b0;
		repeat (4) @(posedge ppu_oe);
		@(negedge ppu_oe);
		init_n = 1'b1;
	end

endmodule

/* test/mmc5_sva.sv */
`timescale 1ns/1ps

module mmc5_sva
(
	input logic ppu_oe,
	input logic in_frame,
	input logic line_start,
	input logic irq,
	input logic irq_ack,
	input logic split_act
);

	// outputs stay quiet between frames
	a_idle_outside_frame: assert property (@(posedge ppu_oe) !in_frame |-> !split_act && !irq)
		else $error("split_act or irq high while in_frame is low");

	a_line_start_single: assert property (@(posedge ppu_oe) disable iff (!in_frame)
		line_start |=> !line_start)
		else $error("line_start high for two cycles in a row");

	a_ack_drops_irq: assert property (@(posedge ppu_oe) disable iff (!in_frame)
		irq && irq_ack |=> !irq)
		else $error("irq still high one cycle after irq_ack");

endmodule

bind mmc5_scanline_unit mmc5_sva u_sva
(
	.ppu_oe(ppu_oe), .in_frame(in_frame), .line_start(line_start), .irq(irq),
	.irq_ack(irq_ack), .split_act(split_act)
);

/* test/tb_mmc5.sv */
`timescale 1ns/1ps

module tb_mmc5;
	import mmc5_pkg::*;

	localparam int FRAMES = 12;
	localparam int MAX_LINES = 12;
	localparam int MAX_FETCH = 180;
	// RAM fill, then per frame the config writes plus the longest lines
	localparam int CYC_LIMIT = 1024 + FRAMES * (16 + MAX_LINES * (MAX_FETCH + 3)) + 500;

	logic               ppu_oe;
	logic               init_n;
	logic               frame_on;
	logic               in_frame;
	logic [PPU_AW-1:0]  ppu_addr;
	logic               cfg_we;
	reg_sel_t           cfg_sel;
	logic [XRAM_AW-1:0] cfg_addr;
	logic [7:0]         cfg_data;
	logic               irq_ack;
	logic               irq;
	logic               split_act;
	logic [9:0]         split_chr_bank;
	logic [7:0]         split_data;

	// reference model
	logic [7:0]        m_mem [0:(1 << XRAM_AW)-1];
	logic [7:0]        m_irq_val, m_scrl, m_bank, m_idx, m_row, m_cnt;
	logic              m_irq_on, m_split_on, m_side, m_marker, m_pend;
	logic [5:0]        m_pos;
	logic [PPU_AW-1:0] m_h1, m_h2;            // last two sampled addresses
	logic [9:0]        q_chr [$];             // due 2 edges after the fetch
	logic              q_act [$];             // due 3 edges after
	logic [8:0]        q_data [$];            // bit 8 marks NT and AT fetches
	int                errors = 0;
	int                checks = 0;
	int                cycles = 0;

	tb_clock u_clk (.ppu_oe(ppu_oe), .init_n(init_n));

	assign in_frame = init_n & frame_on;

	mmc5_scanline_unit dut
	(
		.ppu_oe(ppu_oe), .in_frame(in_frame), .ppu_addr(ppu_addr), .cfg_we(cfg_we),
		.cfg_sel(cfg_sel), .cfg_addr(cfg_addr), .cfg_data(cfg_data), .irq_ack(irq_ack),
		.irq(irq), .split_act(split_act), .split_chr_bank(split_chr_bank),
		.split_data(split_data)
	);

	task automatic check_val(input string name, input logic [9:0] got, input logic [9:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	// called on a falling edge, returns one falling edge later
	task automatic cfg_write(input reg_sel_t sel, input logic [XRAM_AW-1:0] a,
		input logic [7:0] d);
		cfg_we   = 1'b1;
		cfg_sel  = sel;
		cfg_addr = a;
		cfg_data = d;
		case (sel)
			SEL_IRQ_VAL:    m_irq_val = d;
			SEL_IRQ_CTRL:   m_irq_on = d[7];
			SEL_SPLIT_MODE:
			begin
				m_split_on = d[7];
				m_side     = d[6];
				m_pos      = d[5:0];
			end
			SEL_SPLIT_SCRL: m_scrl = d;
			SEL_SPLIT_BANK: m_bank = d;
			default:        m_mem[a] = d;
		endcase
		@(negedge ppu_oe);
		cfg_we = 1'b0;
	endtask

	function automatic fetch_kind_t kind_of(input logic [PPU_AW-1:0] a);
		if (!a[13])
			return FETCH_PAT;
		else if (a[9:6] == 4'b1111)
			return FETCH_AT;
		return FETCH_NT;
	endfunction

	function automatic logic [PPU_AW-1:0] random_fetch();
		logic [31:0] r;
		r = $urandom;
		if (!r[15])
			return {1'b0, r[12:0]};                        // pattern half the time
		else if (!r[14])
			return {1'b1, r[12:0]};                        // mostly nametable
		return {1'b1, r[12:10], 4'b1111, r[5:0]};          // attribute
	endfunction

	// one rising edge of the model with the address and ack sampled there
	task automatic model_step(input logic [PPU_AW-1:0] a, input logic ack);
		logic               mk;
		logic               ls;
		logic [5:0]         col;
		fetch_kind_t        kind;
		logic [XRAM_AW-1:0] xa;
		ls       = m_marker;                      // line_start as seen by this edge
		mk       = a[13] && (a == m_h1) && (m_h1 == m_h2) && !m_marker;
		m_h2     = m_h1;
		m_h1     = a;
		m_marker = mk;
		m_idx    = mk ? 8'd0 : m_idx + 8'd1;
		if (mk)
			m_row = m_row + 8'd1;
		// counter and pending flag act on line_start, one edge after the marker
		if (ack)
			m_pend = 1'b0;
		else if (ls && (m_cnt == m_irq_val))
			m_pend = 1'b1;
		if (ls)
			m_cnt = m_cnt + 8'd1;
		col  = (m_idx >= SPR_FETCH_FIRST && m_idx <= SPR_FETCH_LAST) ? 6'd0 : m_idx[7:2];
		kind = kind_of(a);
		if (kind == FETCH_AT)
			xa = {4'b1111, m_row[7:5], col[4:2]};
		else
			xa = {m_row[7:3], col[4:0]};
		q_chr.push_back({m_bank, a[11:10]});
		q_act.push_back(m_split_on && ((col < m_pos) != m_side));
		q_data.push_back({kind != FETCH_PAT, m_mem[xa]});
	endtask

	task automatic compare_outputs();
		logic [8:0] d;
		check_val("irq", {9'd0, irq}, {9'd0, m_pend & m_irq_on});
		if (q_chr.size() == 3)
			check_val("split_chr_bank", split_chr_bank, q_chr.pop_front());
		if (q_act.size() == 4)
		begin
			check_val("split_act", {9'd0, split_act}, {9'd0, q_act.pop_front()});
			d = q_data.pop_front();
			if (d[8])
				check_val("split_data", {2'd0, split_data}, {2'd0, d[7:0]});
		end
		else
			check_val("split_act", {9'd0, split_act}, 10'd0);   // pipeline still filling
	endtask

	task automatic fetch_cycle(input logic [PPU_AW-1:0] a, input logic ack_mode);
		logic ack;
		ack      = ack_mode && m_pend && m_irq_on && ($urandom_range(7) == 0);
		ppu_addr = a;
		irq_ack  = ack;
		@(negedge ppu_oe);
		model_step(a, ack);
		compare_outputs();
	endtask

	task automatic program_frame();
		logic [31:0] r;
		r = $urandom;
		cfg_write(SEL_IRQ_VAL, '0, {4'd0, r[3:0]});
		cfg_write(SEL_IRQ_CTRL, '0, {r[4] | r[5], 7'd0});         // on in 3 of 4 frames
		cfg_write(SEL_SPLIT_MODE, '0, {r[6] | r[7], r[8], r[14:9]});
		cfg_write(SEL_SPLIT_SCRL, '0, r[22:15]);
		cfg_write(SEL_SPLIT_BANK, '0, r[30:23]);
		repeat (4)
		begin
			r = $urandom;
			cfg_write(SEL_XRAM, r[9:0], r[17:10]);
		end
	endtask

	task automatic run_frame(input int lines, input logic ack_mode);
		logic [31:0]       r;
		logic [PPU_AW-1:0] mark;
		int                n;
		m_h1     = '0;
		m_h2     = '0;
		m_marker = 1'b0;
		m_idx    = 8'd0;
		m_row    = {m_scrl[7:3], 3'b000};
		m_cnt    = 8'd0;
		m_pend   = 1'b0;
		q_chr.delete();
		q_act.delete();
		q_data.delete();
		frame_on = 1'b1;
		for (int l = 0; l < lines; l++)
		begin
			r    = $urandom;
			mark = {1'b1, r[12:0]};
			repeat (3) fetch_cycle(mark, ack_mode);
			n = $urandom_range(MAX_FETCH, 8);
			repeat (n) fetch_cycle(random_fetch(), ack_mode);
		end
		irq_ack  = 1'b0;
		frame_on = 1'b0;                                  // end of frame, irq_on untouched
		@(negedge ppu_oe);
		check_val("irq after frame", {9'd0, irq}, 10'd0);
		check_val("split_act after frame", {9'd0, split_act}, 10'd0);
	endtask

	always @(posedge ppu_oe)
	begin
		cycles++;
		if (cycles > CYC_LIMIT)
		begin
			$display("timeout: no verdict after %0d cycles", CYC_LIMIT);
			$display("** FAIL **");
			$finish;
		end
	end

	initial
	begin
		logic [31:0] r;
		void'($urandom(32'hdd0));
		frame_on = 1'b0;
		ppu_addr = '0;
		cfg_we   = 1'b0;
		cfg_sel  = SEL_IRQ_VAL;
		cfg_addr = '0;
		cfg_data = 8'd0;
		irq_ack  = 1'b0;
		wait (init_n === 1'b1);
		@(negedge ppu_oe);
		for (int i = 0; i < (1 << XRAM_AW); i++)
		begin
			r = $urandom;
			cfg_write(SEL_XRAM, i[XRAM_AW-1:0], r[7:0]);
		end
		for (int f = 0; f < FRAMES; f++)
		begin
			program_frame();
			run_frame($urandom_range(MAX_LINES, 4), f[0]);   // ack only in odd frames
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

/* list.f */
hdl/mmc5_pkg.sv
hdl/mapper_regs.sv
hdl/ppu_fetch_tracker.sv
hdl/scanline_irq.sv
hdl/split_screen.sv
hdl/exram.sv
hdl/mmc5_scanline_unit.sv
test/tb_clock.sv
test/mmc5_sva.sv
test/tb_mmc5.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_mmc5
FILELIST  := list.f
OBJ_DIR   := obj_dir

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)
